// File: rtl/app_pkg.sv
// Shared definitions for the USB CDC application block
// Stream widths, memory geometry, command codes, CRC32 and LFSR
// constants and the controller state encoding
`default_nettype none

package app_pkg;

   typedef logic [7:0]  byte_t;
   typedef logic [31:0] crc_t;
   typedef logic [23:0] lfsr_t;
   // A count field of N means N+1 bytes
   typedef logic [23:0] count_t;

   localparam int MEM_ADDR_W = 10;
   localparam int MEM_SIZE   = 1024;

   typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

   localparam byte_t CMD_IN         = 8'd1;
   localparam byte_t CMD_OUT        = 8'd2;
   localparam byte_t CMD_WAIT       = 8'd3;
   localparam byte_t CMD_LFSR_WRITE = 8'd4;
   localparam byte_t CMD_LFSR_READ  = 8'd5;
   localparam byte_t CMD_ROM_READ   = 8'd6;
   localparam byte_t CMD_RAM_READ   = 8'd7;

   localparam crc_t CRC_POLY = 32'h04C11DB7;
   localparam crc_t CRC_INIT = 32'hFFFFFFFF;

   // Taps at bits 23, 22, 21 and 16
   localparam lfsr_t LFSR_TAPS = 24'hE10000;

   // CMD1..CMD3 and READ0..READ3 must stay consecutive
   typedef enum logic [3:0] {
      ST_RESET,
      ST_LOOPBACK,
      ST_CMD0,
      ST_CMD1,
      ST_CMD2,
      ST_CMD3,
      ST_IN,
      ST_OUT,
      ST_READ0,
      ST_READ1,
      ST_READ2,
      ST_READ3,
      ST_READ_ROM,
      ST_READ_RAM
   } ctrl_state_e;

endpackage

`default_nettype wire

// File: rtl/crc32_acc.sv
// Byte-wide CRC32 accumulator
// Absorbs one byte per update, LSB of the data first, and presents the
// final value inverted with the bits of every byte reversed
`timescale 1ns/1ps
`default_nettype none

module crc32_acc (
   input  wire            clk_i,
   input  wire            rstn,
   input  wire            crc_init_i,
   input  wire            crc_update_i,
   input  app_pkg::byte_t crc_data_i,
   output app_pkg::crc_t  crc_result_o
);
   import app_pkg::*;

   crc_t crc_q;
   crc_t crc_next;

   always_comb begin
      crc_next = crc_q;
      for (int i = 0; i < 8; i++) begin
         if (crc_data_i[i] ^ crc_next[31])
            crc_next = {crc_next[30:0], 1'b0} ^ CRC_POLY;
         else
            crc_next = {crc_next[30:0], 1'b0};
      end
   end

   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         crc_q <= CRC_INIT;
      end else if (crc_init_i) begin
         crc_q <= CRC_INIT;
      end else if (crc_update_i) begin
         crc_q <= crc_next;
      end
   end

   always_comb begin
      for (int k = 0; k < 32; k++) begin
         crc_result_o[(k / 8) * 8 + 7 - (k % 8)] = ~crc_q[k];
      end
   end

endmodule

`default_nettype wire

// File: rtl/byte_rom.sv
// 1024-byte ROM with registered read
// Contents follow a fixed rule: byte at address a is (37a + 11) mod 256
`timescale 1ns/1ps
`default_nettype none

module byte_rom (
   input  wire               clk_i,
   input  wire               en_i,
   input  app_pkg::mem_addr_t addr_i,
   output app_pkg::byte_t    data_o
);
   import app_pkg::*;

   byte_t rom [0:MEM_SIZE-1];

   initial begin
      for (int a = 0; a < MEM_SIZE; a++) begin
         rom[a] = byte_t'((a * 37 + 11) % 256);
      end
   end

   // Output holds while the enable is low
   always_ff @(posedge clk_i) begin
      if (en_i) begin
         data_o <= rom[addr_i];
      end
   end

endmodule

`default_nettype wire

// File: rtl/byte_ram.sv
// 1024-byte single-port RAM
// One access per enabled cycle, either a write or a registered read
`timescale 1ns/1ps
`default_nettype none

module byte_ram (
   input  wire               clk_i,
   input  wire               en_i,
   input  wire               we_i,
   input  app_pkg::mem_addr_t addr_i,
   input  app_pkg::byte_t    wdata_i,
   output app_pkg::byte_t    rdata_o
);
   import app_pkg::*;

   byte_t mem [0:MEM_SIZE-1];

   always_ff @(posedge clk_i) begin
      if (en_i) begin
         if (we_i) begin
            mem[addr_i] <= wdata_i;
         end else begin
            rdata_o <= mem[addr_i];
         end
      end
   end

endmodule

`default_nettype wire

// File: rtl/app_ctrl.sv
// Command FSM of the USB CDC application block
// Echoes host bytes into the RAM in loopback, decodes 0x00-prefixed
// commands, generates LFSR data, paces bytes with the wait gap and
// streams CRC, seed, ROM and RAM contents back to the host
`timescale 1ns/1ps
`default_nettype none

module app_ctrl (
   input  wire                clk_i,
   input  wire                rstn,
   input  app_pkg::byte_t     out_data_i,
   input  wire                out_valid_i,
   output logic               out_ready_o,
   output app_pkg::byte_t     in_data_o,
   output logic               in_valid_o,
   input  wire                in_ready_i,
   output logic               crc_init_o,
   output logic               crc_update_o,
   output app_pkg::byte_t     crc_data_o,
   input  app_pkg::crc_t      crc_result_i,
   output app_pkg::mem_addr_t mem_addr_o,
   output logic               rom_en_o,
   output logic               ram_en_o,
   output logic               ram_we_o,
   output app_pkg::byte_t     ram_wdata_o,
   input  app_pkg::byte_t     rom_data_i,
   input  app_pkg::byte_t     ram_rdata_i
);
   import app_pkg::*;

   ctrl_state_e state_q, state_d;
   byte_t       cmd_q, cmd_d;
   byte_t       data_q, data_d;
   logic        data_valid_q, data_valid_d;
   lfsr_t       lfsr_q, lfsr_d;
   count_t      byte_cnt_q, byte_cnt_d;
   byte_t       wait_q, wait_d;
   byte_t       wait_cnt_q, wait_cnt_d;
   logic        mem_valid_q, mem_valid_d;
   mem_addr_t   mem_addr_q, mem_addr_d;

   logic        data_ready;
   logic        mem_fetch;
   logic        ram_write;
   logic [1:0]  field_sel;
   logic [1:0]  read_sel;
   logic [31:0] lfsr_word;
   byte_t       read_byte;
   byte_t       mem_data;
   lfsr_t       lfsr_next;

   assign lfsr_next = {lfsr_q[22:0], ~^(lfsr_q & LFSR_TAPS)};
   assign field_sel = 2'(state_q - ST_CMD1);
   assign read_sel  = 2'(state_q - ST_READ0);
   // Seed goes out low byte first, then a zero byte
   assign lfsr_word = {8'h00, lfsr_q};
   assign read_byte = (cmd_q == CMD_LFSR_READ) ? lfsr_word[8*read_sel +: 8]
                                               : crc_result_i[8*(3 - read_sel) +: 8];
   assign mem_data  = (state_q == ST_READ_ROM) ? rom_data_i : ram_rdata_i;

   assign crc_init_o  = (state_q == ST_CMD3);
   assign crc_data_o  = (state_q == ST_IN) ? lfsr_q[7:0] : data_q;
   assign mem_addr_o  = mem_addr_q;
   assign rom_en_o    = mem_fetch && (state_q == ST_READ_ROM);
   assign ram_en_o    = ram_write || (mem_fetch && (state_q == ST_READ_RAM));
   assign ram_we_o    = ram_write;
   assign ram_wdata_o = data_q;

   always_comb begin
      state_d      = state_q;
      cmd_d        = cmd_q;
      data_d       = data_q;
      data_valid_d = data_valid_q;
      lfsr_d       = lfsr_q;
      byte_cnt_d   = byte_cnt_q;
      wait_d       = wait_q;
      wait_cnt_d   = (wait_cnt_q != '0) ? wait_cnt_q - 1'b1 : '0;
      mem_valid_d  = mem_valid_q;
      mem_addr_d   = mem_addr_q;
      in_data_o    = data_q;
      in_valid_o   = 1'b0;
      crc_update_o = 1'b0;
      data_ready   = 1'b0;
      mem_fetch    = 1'b0;
      ram_write    = 1'b0;

      case (state_q)
         ST_RESET: begin
            state_d = ST_LOOPBACK;
         end
         ST_LOOPBACK: begin
            if (data_valid_q) begin
               if (data_q == '0) begin
                  data_ready = 1'b1;
                  state_d    = ST_CMD0;
               end else begin
                  in_valid_o = 1'b1;
                  if (in_ready_i) begin
                     data_ready = 1'b1;
                     ram_write  = 1'b1;
                     mem_addr_d = mem_addr_q + 1'b1;
                  end
               end
            end
         end
         ST_CMD0: begin
            if (data_valid_q) begin
               data_ready = 1'b1;
               cmd_d      = data_q;
               state_d    = ST_CMD1;
            end
            mem_valid_d = 1'b0;
            mem_addr_d  = '0;
         end
         ST_CMD1, ST_CMD2, ST_CMD3: begin
            case (cmd_q)
               CMD_IN, CMD_OUT, CMD_ROM_READ, CMD_RAM_READ, CMD_LFSR_WRITE: begin
                  if (data_valid_q) begin
                     data_ready = 1'b1;
                     // Fields arrive low byte first
                     if (cmd_q == CMD_LFSR_WRITE)
                        lfsr_d[8*field_sel +: 8] = data_q;
                     else
                        byte_cnt_d[8*field_sel +: 8] = data_q;
                     if (state_q != ST_CMD3) begin
                        state_d = ctrl_state_e'(state_q + 1'b1);
                     end else begin
                        case (cmd_q)
                           CMD_IN:       state_d = ST_IN;
                           CMD_OUT:      state_d = ST_OUT;
                           CMD_ROM_READ: state_d = ST_READ_ROM;
                           CMD_RAM_READ: state_d = ST_READ_RAM;
                           default:      state_d = ST_LOOPBACK;
                        endcase
                     end
                  end
               end
               CMD_WAIT: begin
                  if (data_valid_q) begin
                     data_ready = 1'b1;
                     wait_d     = data_q;
                     state_d    = ST_LOOPBACK;
                  end
               end
               CMD_LFSR_READ: state_d = ST_READ0;
               default:       state_d = ST_LOOPBACK;
            endcase
         end
         ST_IN: begin
            in_data_o = lfsr_q[7:0];
            if (wait_cnt_q == '0) begin
               in_valid_o = 1'b1;
               if (in_ready_i) begin
                  crc_update_o = 1'b1;
                  lfsr_d       = lfsr_next;
                  wait_cnt_d   = wait_q;
                  if (byte_cnt_q == '0)
                     state_d = ST_READ0;
                  else
                     byte_cnt_d = byte_cnt_q - 1'b1;
               end
            end
         end
         ST_OUT: begin
            if (data_valid_q) begin
               data_ready   = 1'b1;
               crc_update_o = 1'b1;
               if (byte_cnt_q == '0)
                  state_d = ST_READ0;
               else
                  byte_cnt_d = byte_cnt_q - 1'b1;
            end
         end
         ST_READ0, ST_READ1, ST_READ2, ST_READ3: begin
            in_data_o  = read_byte;
            in_valid_o = 1'b1;
            if (in_ready_i)
               state_d = (state_q == ST_READ3) ? ST_LOOPBACK : ctrl_state_e'(state_q + 1'b1);
         end
         ST_READ_ROM, ST_READ_RAM: begin
            in_data_o = mem_data;
            // Fetch one byte, present it, then fetch the next after its transfer
            if (!mem_valid_q) begin
               mem_fetch   = 1'b1;
               mem_valid_d = 1'b1;
               mem_addr_d  = mem_addr_q + 1'b1;
            end
            if (wait_cnt_q == '0) begin
               in_valid_o = mem_valid_q;
               if (in_ready_i && mem_valid_q) begin
                  mem_valid_d = 1'b0;
                  wait_cnt_d  = wait_q;
                  if (byte_cnt_q == '0) begin
                     state_d    = ST_LOOPBACK;
                     mem_addr_d = '0;
                  end else begin
                     byte_cnt_d = byte_cnt_q - 1'b1;
                  end
               end
            end
         end
         default: state_d = ST_LOOPBACK;
      endcase

      // Input byte register
      out_ready_o = out_valid_i && (state_q != ST_RESET) && (wait_cnt_q == '0) &&
                    (!data_valid_q || data_ready);
      if (out_ready_o) begin
         data_d       = out_data_i;
         data_valid_d = 1'b1;
         wait_cnt_d   = wait_q;
      end else if (data_ready) begin
         data_valid_d = 1'b0;
      end
   end

   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         state_q      <= ST_RESET;
         cmd_q        <= '0;
         data_valid_q <= 1'b0;
         lfsr_q       <= '0;
         byte_cnt_q   <= '0;
         wait_q       <= '0;
         wait_cnt_q   <= '0;
         mem_valid_q  <= 1'b0;
         mem_addr_q   <= '0;
      end else begin
         state_q      <= state_d;
         cmd_q        <= cmd_d;
         data_valid_q <= data_valid_d;
         lfsr_q       <= lfsr_d;
         byte_cnt_q   <= byte_cnt_d;
         wait_q       <= wait_d;
         wait_cnt_q   <= wait_cnt_d;
         mem_valid_q  <= mem_valid_d;
         mem_addr_q   <= mem_addr_d;
      end
   end

   always_ff @(posedge clk_i) begin
      data_q <= data_d;
   end

endmodule

`default_nettype wire

// File: rtl/app_top.sv
// Top level of the USB CDC application block
// Synchronizes the reset release and connects the command FSM to
// the CRC32 accumulator, the ROM and the RAM
`timescale 1ns/1ps
`default_nettype none

module app_top (
   input  wire            clk_i,
   input  wire            rstn_i,
   input  app_pkg::byte_t out_data_i,
   input  wire            out_valid_i,
   output logic           out_ready_o,
   output app_pkg::byte_t in_data_o,
   output logic           in_valid_o,
   input  wire            in_ready_i
);
   import app_pkg::*;

   logic [1:0] rstn_sq;
   logic       rstn;

   logic       crc_init;
   logic       crc_update;
   byte_t      crc_data;
   crc_t       crc_result;
   mem_addr_t  mem_addr;
   logic       rom_en;
   logic       ram_en;
   logic       ram_we;
   byte_t      ram_wdata;
   byte_t      rom_data;
   byte_t      ram_rdata;

   // Asynchronous assert, release two clocks after rstn_i rises
   always_ff @(posedge clk_i or negedge rstn_i) begin
      if (!rstn_i) begin
         rstn_sq <= 2'b00;
      end else begin
         rstn_sq <= {1'b1, rstn_sq[1]};
      end
   end

   assign rstn = rstn_sq[0];

   app_ctrl u_ctrl (
      .clk_i        (clk_i),
      .rstn         (rstn),
      .out_data_i   (out_data_i),
      .out_valid_i  (out_valid_i),
      .out_ready_o  (out_ready_o),
      .in_data_o    (in_data_o),
      .in_valid_o   (in_valid_o),
      .in_ready_i   (in_ready_i),
      .crc_init_o   (crc_init),
      .crc_update_o (crc_update),
      .crc_data_o   (crc_data),
      .crc_result_i (crc_result),
      .mem_addr_o   (mem_addr),
      .rom_en_o     (rom_en),
      .ram_en_o     (ram_en),
      .ram_we_o     (ram_we),
      .ram_wdata_o  (ram_wdata),
      .rom_data_i   (rom_data),
      .ram_rdata_i  (ram_rdata)
   );

   crc32_acc u_crc (
      .clk_i        (clk_i),
      .rstn         (rstn),
      .crc_init_i   (crc_init),
      .crc_update_i (crc_update),
      .crc_data_i   (crc_data),
      .crc_result_o (crc_result)
   );

   byte_rom u_rom (
      .clk_i  (clk_i),
      .en_i   (rom_en),
      .addr_i (mem_addr),
      .data_o (rom_data)
   );

   byte_ram u_ram (
      .clk_i   (clk_i),
      .en_i    (ram_en),
      .we_i    (ram_we),
      .addr_i  (mem_addr),
      .wdata_i (ram_wdata),
      .rdata_o (ram_rdata)
   );

endmodule

`default_nettype wire

// File: verification/app_properties.sv
// Handshake checks for the application FSM
// Bound into app_ctrl, watches the device-to-host stream, the reset
// behavior of both handshakes and the state register
`timescale 1ns/1ps
`default_nettype none

module app_properties (
   input wire                  clk_i,
   input wire                  rstn,
   input app_pkg::byte_t       in_data_i,
   input wire                  in_valid_i,
   input wire                  in_ready_i,
   input wire                  out_ready_i,
   input app_pkg::ctrl_state_e state_i
);
   import app_pkg::*;

   int fail_count = 0;

   // A stalled byte stays on the bus unchanged
   a_in_data_stable: assert property (@(posedge clk_i) disable iff (!rstn)
      in_valid_i && !in_ready_i |=> in_valid_i && $stable(in_data_i))
      else begin
         fail_count++;
         $error("in_data_o dropped or changed while in_ready_i was low");
      end

   a_reset_quiet: assert property (@(posedge clk_i)
      !rstn |-> !in_valid_i && !out_ready_i)
      else begin
         fail_count++;
         $error("in_valid_o or out_ready_o high during reset");
      end

   a_state_legal: assert property (@(posedge clk_i) disable iff (!rstn)
      state_i inside {ST_RESET, ST_LOOPBACK, ST_CMD0, ST_CMD1, ST_CMD2, ST_CMD3,
                      ST_IN, ST_OUT, ST_READ0, ST_READ1, ST_READ2, ST_READ3,
                      ST_READ_ROM, ST_READ_RAM})
      else begin
         fail_count++;
         $error("controller state outside ctrl_state_e");
      end

endmodule

bind app_ctrl app_properties u_props (
   .clk_i       (clk_i),
   .rstn        (rstn),
   .in_data_i   (in_data_o),
   .in_valid_i  (in_valid_o),
   .in_ready_i  (in_ready_i),
   .out_ready_i (out_ready_o),
   .state_i     (state_q)
);

`default_nettype wire

// File: verification/tb_app.sv
// Testbench for the USB CDC application block
// Host model on both byte streams, reference models for CRC32, LFSR and
// ROM contents, and a compare process on the bytes the DUT returns
`timescale 1ns/1ps
`default_nettype none

module tb_app;
   import app_pkg::*;

   localparam int N_LOOP   = 32;
   localparam int N_IN     = 20;
   localparam int N_OUT    = 24;
   localparam int N_ROM    = 16;
   localparam int N_WAIT   = 8;
   localparam int WAIT_GAP = 5;
   // Sent plus returned bytes of all tests, with room for the command bytes
   localparam int TOTAL_BYTES    = 3 * N_LOOP + N_IN + N_OUT + N_ROM + 2 * N_WAIT + 48;
   localparam int TIMEOUT_CYCLES = 200 * TOTAL_BYTES + 500;

   logic   clk_i;
   logic   rstn_i;
   byte_t  out_data_i;
   logic   out_valid_i;
   logic   out_ready_o;
   byte_t  in_data_o;
   logic   in_valid_o;
   logic   in_ready_i = 1'b0;

   integer seed = 98;
   logic   rand_ready = 1'b1;
   int     cycle = 0;
   int     checks = 0;
   int     errors = 0;
   int     gap_errors = 0;
   int     err_mark = 0;
   int     test_num = 0;
   byte_t  rx_byte;
   byte_t  tx_q[$];
   byte_t  exp_q[$];
   byte_t  rx_q[$];
   byte_t  ram_q[$];
   int     accept_t[$];

   app_top DUT (
      .clk_i       (clk_i),
      .rstn_i      (rstn_i),
      .out_data_i  (out_data_i),
      .out_valid_i (out_valid_i),
      .out_ready_o (out_ready_o),
      .in_data_o   (in_data_o),
      .in_valid_o  (in_valid_o),
      .in_ready_i  (in_ready_i)
   );

   initial begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   // Both handshakes are sampled on the rising edge
   always @(posedge clk_i) begin
      cycle <= cycle + 1;
      if (in_valid_o && in_ready_i)
         rx_q.push_back(in_data_o);
      if (out_valid_i && out_ready_o)
         accept_t.push_back(cycle);
   end

   always @(negedge clk_i) begin
      in_ready_i = rand_ready ? (($random(seed) & 3) != 0) : 1'b1;
   end

   function automatic byte_t nonzero_byte();
      byte_t b;
      b = byte_t'($random(seed));
      while (b == 8'h00)
         b = byte_t'($random(seed));
      return b;
   endfunction

   // Standard reflected CRC32
   function automatic logic [31:0] ref_crc32(input byte_t data[$]);
      logic [31:0] crc;
      crc = 32'hFFFFFFFF;
      foreach (data[i]) begin
         crc = crc ^ {24'h0, data[i]};
         for (int k = 0; k < 8; k++) begin
            if (crc[0])
               crc = (crc >> 1) ^ 32'hEDB88320;
            else
               crc = crc >> 1;
         end
      end
      return ~crc;
   endfunction

   // New bit is the XNOR of taps 23, 22, 21 and 16
   function automatic lfsr_t ref_lfsr_next(input lfsr_t s);
      logic fb;
      fb = ~(s[23] ^ s[22] ^ s[21] ^ s[16]);
      return {s[22:0], fb};
   endfunction

   function automatic byte_t ref_rom_byte(input int a);
      return byte_t'((a * 37 + 11) % 256);
   endfunction

   function automatic int total_errors();
      return errors + gap_errors + DUT.u_ctrl.u_props.fail_count;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error: %s is 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic push_cmd(input byte_t cmd);
      tx_q.push_back(8'h00);
      tx_q.push_back(cmd);
   endtask

   // Count and seed fields go low byte first
   task automatic push_field(input logic [23:0] v);
      tx_q.push_back(v[7:0]);
      tx_q.push_back(v[15:8]);
      tx_q.push_back(v[23:16]);
   endtask

   // Device word is the standard CRC32 with its bytes swapped and goes out MSB first
   task automatic push_crc(input logic [31:0] crc);
      exp_q.push_back(crc[7:0]);
      exp_q.push_back(crc[15:8]);
      exp_q.push_back(crc[23:16]);
      exp_q.push_back(crc[31:24]);
   endtask

   task automatic send_all();
      while (tx_q.size() != 0) begin
         @(negedge clk_i);
         out_data_i  = tx_q.pop_front();
         out_valid_i = 1'b1;
         @(posedge clk_i);
         while (!out_ready_o)
            @(posedge clk_i);
      end
      @(negedge clk_i);
      out_valid_i = 1'b0;
   endtask

   task automatic end_test(input string name);
      int n;
      @(posedge clk_i);
      while (exp_q.size() != 0 || rx_q.size() != 0)
         @(posedge clk_i);
      repeat (8) @(posedge clk_i);
      n = total_errors() - err_mark;
      test_num++;
      if (n == 0)
         $display("Test %0d (%s) done: ok", test_num, name);
      else
         $display("Test %0d (%s) done: %0d errors", test_num, name, n);
      err_mark = total_errors();
   endtask

   initial begin
      forever begin
         @(negedge clk_i);
         while (rx_q.size() != 0) begin
            rx_byte = rx_q.pop_front();
            if (exp_q.size() == 0) begin
               $display("Unexpected byte 0x%0h on in_data_o with nothing expected", rx_byte);
               errors++;
            end else begin
               check_value("in_data_o", {24'h0, rx_byte}, {24'h0, exp_q.pop_front()});
            end
         end
      end
   end

   initial begin
      byte_t b;
      lfsr_t lfsr;
      byte_t data[$];
      rstn_i      = 1'b0;
      out_data_i  = 8'h00;
      out_valid_i = 1'b0;
      repeat (8) @(negedge clk_i);
      rstn_i = 1'b1;

      for (int i = 0; i < N_LOOP; i++) begin
         b = nonzero_byte();
         tx_q.push_back(b);
         exp_q.push_back(b);
         ram_q.push_back(b);
      end
      send_all();
      end_test("loopback");

      push_cmd(CMD_RAM_READ);
      push_field(24'(ram_q.size() - 1));
      foreach (ram_q[i])
         exp_q.push_back(ram_q[i]);
      send_all();
      end_test("ram read");

      lfsr = lfsr_t'($random(seed));
      push_cmd(CMD_LFSR_WRITE);
      push_field(lfsr);
      push_cmd(CMD_LFSR_READ);
      exp_q.push_back(lfsr[7:0]);
      exp_q.push_back(lfsr[15:8]);
      exp_q.push_back(lfsr[23:16]);
      exp_q.push_back(8'h00);
      push_cmd(CMD_IN);
      push_field(24'(N_IN - 1));
      for (int i = 0; i < N_IN; i++) begin
         exp_q.push_back(lfsr[7:0]);
         data.push_back(lfsr[7:0]);
         lfsr = ref_lfsr_next(lfsr);
      end
      push_crc(ref_crc32(data));
      send_all();
      end_test("lfsr seed and in");

      rand_ready = 1'b0;
      data.delete();
      push_cmd(CMD_OUT);
      push_field(24'(N_OUT - 1));
      for (int i = 0; i < N_OUT; i++) begin
         b = byte_t'($random(seed));
         data.push_back(b);
         tx_q.push_back(b);
      end
      push_crc(ref_crc32(data));
      send_all();
      end_test("out crc");

      rand_ready = 1'b1;
      push_cmd(CMD_ROM_READ);
      push_field(24'(N_ROM - 1));
      for (int a = 0; a < N_ROM; a++)
         exp_q.push_back(ref_rom_byte(a));
      send_all();
      end_test("rom read");

      rand_ready = 1'b0;
      push_cmd(CMD_WAIT);
      tx_q.push_back(8'(WAIT_GAP));
      for (int i = 0; i < N_WAIT; i++) begin
         b = nonzero_byte();
         tx_q.push_back(b);
         exp_q.push_back(b);
      end
      accept_t.delete();
      send_all();
      // The new gap paces host bytes from the second data byte on
      for (int i = 5; i < accept_t.size(); i++) begin
         if (accept_t[i] - accept_t[i-1] < WAIT_GAP) begin
            $display("Host bytes %0d and %0d were accepted only %0d cycles apart",
                     i - 1, i, accept_t[i] - accept_t[i-1]);
            gap_errors++;
         end
      end
      end_test("wait gap");

      $display("Checks: %0d, errors: %0d", checks, total_errors());
      if (total_errors() == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge clk_i);
      $display("Timeout after %0d cycles with %0d bytes still expected",
               TIMEOUT_CYCLES, exp_q.size());
      $display("Simulation FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: filelist.f
rtl/app_pkg.sv
rtl/crc32_acc.sv
rtl/byte_rom.sv
rtl/byte_ram.sv
rtl/app_ctrl.sv
rtl/app_top.sv
verification/app_properties.sv
verification/tb_app.sv

// File: Makefile
# Verilator build and run for the USB CDC application block

TOP := tb_app

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation PASSED" sim.log

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f filelist.f

clean:
	rm -rf obj_dir sim.log
